// File: conv_engine.f
hw/conv_pkg.sv
hw/n_delay.sv
hw/processing_element.sv
hw/conv_control.sv
hw/conv_engine.sv
test/conv_engine_checker.sv
test/conv_engine_tb.sv

// File: hw/conv_control.sv
// Stall, opcode decode and valid/last pipeline shared by all processing elements of the engine.
`timescale 1ns/1ps
`default_nettype none

module conv_control (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 s_valid,
  output logic                 s_ready,
  input  conv_pkg::conv_ctrl_t s_ctrl,
  input  logic                 m_ready,
  output logic                 m_valid,
  output logic                 m_last,
  output logic                 mul_en,
  output logic                 acc_en,
  output logic                 bypass
);
  import conv_pkg::*;

  logic en;
  logic start;
  logic emit;
  logic acc_valid;
  logic acc_start;
  logic acc_emit;
  logic acc_last;
  logic emit_valid;

  // the whole pipe freezes while an output waits.
  assign en      = !m_valid || m_ready;
  assign s_ready = en;

  assign mul_en = en && s_valid;
  // stages behind the input register step with the global enable.
  assign acc_en = en;

  always_comb begin
    start = 1'b0;
    emit  = 1'b0;
    case (s_ctrl.op)
      OP_MAC: begin
        start = 1'b0;
        emit  = 1'b0;
      end
      OP_FIRST: begin
        start = 1'b1;
        emit  = 1'b0;
      end
      OP_LAST: begin
        start = 1'b0;
        emit  = 1'b1;
      end
      OP_SINGLE: begin
        start = 1'b1;
        emit  = 1'b1;
      end
      default: begin
        start = 1'b0;
        emit  = 1'b0;
      end
    endcase
  end

  // carries the decoded bits to the accumulate stage.
  n_delay #(
    .N          (LATENCY_MUL),
    .WORD_WIDTH (4)
  ) u_mul_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .data_in  ({s_valid, start, emit, s_ctrl.last}),
    .data_out ({acc_valid, acc_start, acc_emit, acc_last})
  );

  assign bypass     = acc_valid && acc_start;
  assign emit_valid = acc_valid && acc_emit;

  // output flags hold while en is low.
  n_delay #(
    .N          (LATENCY_ACC),
    .WORD_WIDTH (2)
  ) u_acc_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .data_in  ({emit_valid, acc_last}),
    .data_out ({m_valid, m_last})
  );

endmodule

`default_nettype wire

// File: hw/conv_engine.sv
// Convolution engine top: control block plus the MEMBERS by UNITS grid of MAC elements.
`timescale 1ns/1ps
`default_nettype none

module conv_engine (
  input  logic                 clk,
  input  logic                 rst_n,

  input  logic                 s_valid,
  output logic                 s_ready,
  input  conv_pkg::conv_in_t   s_data,
  input  conv_pkg::conv_ctrl_t s_ctrl,

  output logic                 m_valid,
  input  logic                 m_ready,
  output conv_pkg::conv_out_t  m_data,
  output logic                 m_last
);
  import conv_pkg::*;

  logic mul_en;
  logic acc_en;
  logic bypass;

  conv_control u_control (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_ctrl  (s_ctrl),
    .m_ready (m_ready),
    .m_valid (m_valid),
    .m_last  (m_last),
    .mul_en  (mul_en),
    .acc_en  (acc_en),
    .bypass  (bypass)
  );

  // element (m, u) sees pixel u and weight m.
  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      processing_element u_pe (
        .clk    (clk),
        .rst_n  (rst_n),
        .mul_en (mul_en),
        .acc_en (acc_en),
        .bypass (bypass),
        .pixel  (s_data.pixels[u]),
        .weight (s_data.weights[m]),
        .sum    (m_data.sums[m][u])
      );
    end
  end

endmodule

`default_nettype wire

// File: hw/conv_pkg.sv
// Sizes, latencies, opcodes and stream types shared by every convolution engine block.
`default_nettype none

package conv_pkg;

  // grid size.
  localparam int UNITS          = 4;
  localparam int MEMBERS        = 4;

  localparam int WORD_WIDTH_IN  = 8;
  localparam int WORD_WIDTH_OUT = 24;

  // pipeline depths in enabled cycles.
  localparam int LATENCY_MUL    = 2;
  localparam int LATENCY_ACC    = 1;
  localparam int LATENCY        = LATENCY_MUL + LATENCY_ACC;

  typedef enum logic [1:0] {
    OP_MAC    = 2'd0,
    OP_FIRST  = 2'd1,
    OP_LAST   = 2'd2,
    OP_SINGLE = 2'd3
  } conv_op_e;

  // one input beat of operands.
  typedef struct packed {
    logic [UNITS-1:0][WORD_WIDTH_IN-1:0]   pixels;
    logic [MEMBERS-1:0][WORD_WIDTH_IN-1:0] weights;
  } conv_in_t;

  typedef struct packed {
    conv_op_e op;
    logic     last;
  } conv_ctrl_t;

  // sums indexed as [member][unit].
  typedef struct packed {
    logic [MEMBERS-1:0][UNITS-1:0][WORD_WIDTH_OUT-1:0] sums;
  } conv_out_t;

endpackage

`default_nettype wire

// File: hw/n_delay.sv
// Enabled delay line of N reset registers, used for the operand and control pipes.
`timescale 1ns/1ps
`default_nettype none

module n_delay #(
  parameter int N          = 1,
  parameter int WORD_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic [WORD_WIDTH-1:0] data_in,
  output logic [WORD_WIDTH-1:0] data_out
);

  generate
    if (N == 0) begin : g_pass
      assign data_out = data_in;
    end else begin : g_pipe
      logic [WORD_WIDTH-1:0] stage [N];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int i = 0; i < N; i++) begin
            stage[i] <= '0;
          end
        end else if (en) begin
          stage[0] <= data_in;
          // shift toward the output.
          for (int i = 1; i < N; i++) begin
            stage[i] <= stage[i-1];
          end
        end
      end

      assign data_out = stage[N-1];
    end
  endgenerate

endmodule

`default_nettype wire

// File: hw/processing_element.sv
// One pixel by weight multiply and accumulate lane, instantiated across the engine grid.
`timescale 1ns/1ps
`default_nettype none

module processing_element (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      mul_en,
  input  logic                                      acc_en,
  input  logic                                      bypass,
  input  logic signed [conv_pkg::WORD_WIDTH_IN-1:0]  pixel,
  input  logic signed [conv_pkg::WORD_WIDTH_IN-1:0]  weight,
  output logic signed [conv_pkg::WORD_WIDTH_OUT-1:0] sum
);
  import conv_pkg::*;

  logic                                nonzero;
  logic                                op_valid;
  logic                                prod_valid;
  logic signed [WORD_WIDTH_IN-1:0]     pixel_q;
  logic signed [WORD_WIDTH_IN-1:0]     weight_q;
  logic signed [2*WORD_WIDTH_IN-1:0]   product;
  logic signed [WORD_WIDTH_OUT-1:0]    product_ext;
  logic signed [WORD_WIDTH_OUT-1:0]    sum_next;

  // zero operands leave the multiplier registers idle.
  assign nonzero = (pixel != '0) && (weight != '0);

  n_delay #(
    .N          (LATENCY_MUL - 1),
    .WORD_WIDTH (2 * WORD_WIDTH_IN)
  ) u_operands (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (mul_en && nonzero),
    .data_in  ({pixel, weight}),
    .data_out ({pixel_q, weight_q})
  );

  // valid moves every enabled cycle so bubbles are tracked.
  n_delay #(
    .N          (LATENCY_MUL - 1),
    .WORD_WIDTH (1)
  ) u_op_valid (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (acc_en),
    .data_in  (mul_en && nonzero),
    .data_out (op_valid)
  );

  // last multiplier stage.
  always_ff @(posedge clk) begin
    if (acc_en && op_valid) begin
      product <= pixel_q * weight_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
    end else if (acc_en) begin
      prod_valid <= op_valid;
    end
  end

  assign product_ext = {{(WORD_WIDTH_OUT - 2*WORD_WIDTH_IN){product[2*WORD_WIDTH_IN-1]}},
                        product};

  // wraps at the accumulator width.
  assign sum_next = (prod_valid ? product_ext : '0) + (bypass ? '0 : sum);

  always_ff @(posedge clk) begin
    if (acc_en && (prod_valid || bypass)) begin
      sum <= sum_next;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module conv_engine_tb -f conv_engine.f \
  -o conv_engine_sim \
  && ./obj_dir/conv_engine_sim \
  || { echo "run ended with an error status"; exit 1; }

// File: test/conv_engine_checker.sv
// Bound assertions on the stream handshakes of the convolution engine, attached by bind.
`timescale 1ns/1ps
`default_nettype none

module conv_engine_checker (
  input logic                clk,
  input logic                rst_n,
  input logic                s_valid,
  input logic                s_ready,
  input conv_pkg::conv_in_t  s_data,
  input logic                m_valid,
  input logic                m_ready,
  input conv_pkg::conv_out_t m_data
);

  // a stalled source holds its beat.
  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    s_valid && !s_ready |=> s_valid && $stable(s_data))
    else $error("input beat changed while s_ready was low");

  // the engine freezes its output under back-pressure.
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid && $stable(m_data))
    else $error("output beat changed while m_ready was low");

  // first edge out of reset.
  a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !m_valid)
    else $error("m_valid high right after reset");

endmodule

bind conv_engine conv_engine_checker u_checker (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_valid (s_valid),
  .s_ready (s_ready),
  .s_data  (s_data),
  .m_valid (m_valid),
  .m_ready (m_ready),
  .m_data  (m_data)
);

`default_nettype wire

// File: test/conv_engine_tb.sv
// Table-driven testbench for the convolution engine, checking outputs against a model of the sums.
`timescale 1ns/1ps
`default_nettype none

module conv_engine_tb;
  import conv_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int LONG_MACS    = 520;
  localparam int RANDOM_ROWS  = 40;
  localparam int NUM_ROWS     = 7 + LONG_MACS + 2 + RANDOM_ROWS;
  localparam int CYCLE_LIMIT  = 2 * NUM_ROWS * 4 + RESET_CYCLES;

  typedef struct {
    conv_in_t                  data;
    conv_ctrl_t                ctrl;
    logic                      rdy_rand;
    logic                      has_exp;
    logic [WORD_WIDTH_OUT-1:0] exp00;
  } row_t;

  typedef struct {
    conv_out_t                 data;
    logic                      last;
    int                        accept_en;
    logic                      has_exp;
    logic [WORD_WIDTH_OUT-1:0] exp00;
  } expect_t;

  logic       clk;
  logic       rst_n;
  logic       s_valid;
  logic       s_ready;
  conv_in_t   s_data;
  conv_ctrl_t s_ctrl;
  logic       m_valid;
  logic       m_ready;
  conv_out_t  m_data;
  logic       m_last;

  row_t                             tbl [NUM_ROWS];
  expect_t                          exp_q [$];
  logic signed [WORD_WIDTH_OUT-1:0] model_sum [MEMBERS][UNITS];
  integer                           seed = 38;
  int                               n_rows = 0;
  int                               en_edges = 0;
  int                               cur_row = 0;
  int                               cycle = 0;
  logic                             ready_rand = 1'b0;

  conv_engine dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .s_ctrl  (s_ctrl),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data),
    .m_last  (m_last)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(input logic [383:0] got, input logic [383:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  task automatic add_row(input logic [31:0] px, input logic [31:0] wt, input conv_op_e op,
                         input logic last, input logic rdy, input logic has_exp,
                         input logic [WORD_WIDTH_OUT-1:0] exp00);
    tbl[n_rows].data.pixels  = px;
    tbl[n_rows].data.weights = wt;
    tbl[n_rows].ctrl.op      = op;
    tbl[n_rows].ctrl.last    = last;
    tbl[n_rows].rdy_rand     = rdy;
    tbl[n_rows].has_exp      = has_exp;
    tbl[n_rows].exp00        = exp00;
    n_rows++;
  endtask

  // exp00 is the hand-worked sum of element (0,0) from the low byte of each word.
  task automatic build_table();
    logic [31:0] px;
    logic [31:0] wt;
    add_row(32'h04030201, 32'h08070605, OP_SINGLE, 1'b1, 1'b0, 1'b1, 24'd5);
    add_row(32'h7f00810a, 32'hff800203, OP_FIRST,  1'b0, 1'b0, 1'b0, 24'd0);
    add_row(32'h05fe80fe, 32'h01027f07, OP_MAC,    1'b0, 1'b0, 1'b0, 24'd0);
    add_row(32'h00330000, 32'h9c000105, OP_MAC,    1'b0, 1'b0, 1'b0, 24'd0);
    add_row(32'h81ff0204, 32'h7f8001fc, OP_LAST,   1'b1, 1'b0, 1'b1, 24'd0);
    add_row(32'h10203002, 32'h0f0e0d02, OP_FIRST,  1'b0, 1'b0, 1'b0, 24'd0);
    add_row(32'h80017f01, 32'hff7f8001, OP_LAST,   1'b0, 1'b0, 1'b1, 24'd5);
    // 522 products of 16384 run past the signed 24-bit range.
    add_row(32'h80808080, 32'h80808080, OP_FIRST,  1'b0, 1'b0, 1'b0, 24'd0);
    for (int i = 0; i < LONG_MACS; i++) begin
      add_row(32'h80808080, 32'h80808080, OP_MAC, 1'b0, 1'b0, 1'b0, 24'd0);
    end
    add_row(32'h80808080, 32'h80808080, OP_LAST,   1'b1, 1'b0, 1'b1, 24'h828000);
    for (int i = 0; i < RANDOM_ROWS; i++) begin
      px = $random(seed);
      wt = $random(seed);
      if (i % 4 == 0) begin
        px[15:8] = 8'h00;
      end
      add_row(px, wt, OP_SINGLE, i[0], 1'b1, 1'b0, 24'd0);
    end
  endtask

  task automatic accept_beat();
    logic signed [WORD_WIDTH_IN-1:0]  px;
    logic signed [WORD_WIDTH_IN-1:0]  wt;
    logic signed [WORD_WIDTH_OUT-1:0] prod;
    logic                             start;
    logic                             emit;
    expect_t                          e;
    start = (s_ctrl.op == OP_FIRST) || (s_ctrl.op == OP_SINGLE);
    emit  = (s_ctrl.op == OP_LAST) || (s_ctrl.op == OP_SINGLE);
    for (int m = 0; m < MEMBERS; m++) begin
      for (int u = 0; u < UNITS; u++) begin
        px = s_data.pixels[u];
        wt = s_data.weights[m];
        prod = WORD_WIDTH_OUT'(px) * WORD_WIDTH_OUT'(wt);
        model_sum[m][u] = start ? prod : model_sum[m][u] + prod;
        e.data.sums[m][u] = model_sum[m][u];
      end
    end
    if (emit) begin
      e.last      = s_ctrl.last;
      e.accept_en = en_edges;
      e.has_exp   = tbl[cur_row].has_exp;
      e.exp00     = tbl[cur_row].exp00;
      exp_q.push_back(e);
    end
  endtask

  task automatic compare_output();
    expect_t e;
    if (exp_q.size() == 0) begin
      $display("Output beat at %0t arrived with no expected beat pending", $time);
      $display("Simulation failed");
      $fatal(1, "unexpected output beat");
    end else begin
      e = exp_q.pop_front();
      check(m_data, e.data, "m_data");
      check(m_last, e.last, "m_last");
      check(en_edges, e.accept_en + LATENCY, "enabled cycles to output");
      if (e.has_exp) begin
        check(m_data.sums[0][0], e.exp00, "sum (0,0)");
      end
    end
  endtask

  // inputs and outputs are all settled at the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      check(s_ready, !(m_valid && !m_ready), "s_ready");
      if (m_valid && m_ready) begin
        compare_output();
      end
      if (s_valid && s_ready) begin
        accept_beat();
      end
      if (s_ready) begin
        en_edges++;
      end
    end
  end

  initial begin
    logic rand_now;
    m_ready = 1'b1;
    forever begin
      @(posedge clk);
      rand_now = ready_rand;
      #1;
      m_ready = rand_now ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  initial begin
    forever begin
      @(posedge clk);
      cycle++;
      if (cycle > CYCLE_LIMIT) begin
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    rst_n   = 1'b0;
    s_valid = 1'b0;
    s_data  = '0;
    s_ctrl  = '{op: OP_MAC, last: 1'b0};
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check(m_valid, 1'b0, "m_valid after reset");
    check(s_ready, 1'b1, "s_ready after reset");
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(posedge clk);
      #1;
      cur_row    = i;
      ready_rand = tbl[i].rdy_rand;
      s_valid    = 1'b1;
      s_data     = tbl[i].data;
      s_ctrl     = tbl[i].ctrl;
      do begin
        @(negedge clk);
      end while (!s_ready);
    end
    @(posedge clk);
    #1;
    s_valid    = 1'b0;
    ready_rand = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    // catch any extra beat behind the last one.
    repeat (LATENCY + 2) @(negedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
